// ==== build.f ====
+incdir+src
src/tcp_mem_pkg.sv
src/axis_word_if.sv
src/axis_64_to_512_upsizer.sv
src/mem_write_arbiter.sv
src/tcp_mem_write_path.sv
bench/write_path_checker.sv
bench/tb_tcp_mem_write_path.sv

// ==== Bender.yml ====
package:
  name: tcp_mem_write_path

sources:
  - include_dirs:
      - src
    files:
      - src/tcp_mem_pkg.sv
      - src/axis_word_if.sv
      - src/axis_64_to_512_upsizer.sv
      - src/mem_write_arbiter.sv
      - src/tcp_mem_write_path.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/write_path_checker.sv
      - bench/tb_tcp_mem_write_path.sv

// ==== bench/tb_tcp_mem_write_path.sv ====
`timescale 1ns/1ps

module tb_tcp_mem_write_path;

  localparam int MAX_TESTS = 8;

  logic net_clk = 1'b0;
  logic rst;
  logic tx_cmd_valid, rx_cmd_valid;
  logic tx_cmd_ready, rx_cmd_ready;
  tcp_mem_pkg::mem_cmd_raw_t tx_cmd_data, rx_cmd_data;
  logic tx_data_valid, rx_data_valid;
  logic tx_data_ready, rx_data_ready;
  tcp_mem_pkg::word64_t tx_data_data, rx_data_data;
  tcp_mem_pkg::keep8_t tx_data_keep, rx_data_keep;
  logic tx_data_last, rx_data_last;
  logic mem_cmd_valid;
  logic mem_cmd_ready = 1'b0;
  tcp_mem_pkg::mem_addr_t mem_cmd_addr;
  tcp_mem_pkg::mem_len_t mem_cmd_len;
  tcp_mem_pkg::chan_t mem_cmd_dest;
  logic mem_data_valid;
  logic mem_data_ready = 1'b0;
  tcp_mem_pkg::word512_t mem_data_data;
  tcp_mem_pkg::keep64_t mem_data_keep;
  logic mem_data_last;
  tcp_mem_pkg::chan_t mem_data_dest;
  int tests_done, tests_failed, other_errors;
  integer rand_seed = 32'h6e99;

  // test table, one row per burst
  string t_name [MAX_TESTS];
  bit t_chan [MAX_TESTS];
  tcp_mem_pkg::mem_cmd_raw_t t_cmd [MAX_TESTS];
  int t_beats [MAX_TESTS];
  tcp_mem_pkg::word64_t t_seed [MAX_TESTS]; // beat i carries seed + i
  tcp_mem_pkg::keep8_t t_last_keep [MAX_TESTS];
  int t_words [MAX_TESTS]; // memory words expected
  int n_tests;

  tcp_mem_write_path dut_i (.*);
  write_path_checker checker_i (.*);

  always #4 net_clk = ~net_clk;

  always @(posedge net_clk) begin
    logic [31:0] rnd;
    #1;
    rnd = $random(rand_seed);
    mem_cmd_ready = rnd[0];
    mem_data_ready = rnd[1];
  end

  task automatic add_test(input string name, input bit chan, input tcp_mem_pkg::mem_cmd_raw_t cmd,
                          input int beats, input tcp_mem_pkg::word64_t data_seed,
                          input tcp_mem_pkg::keep8_t last_keep, input int words);
    t_name[n_tests] = name;
    t_chan[n_tests] = chan;
    t_cmd[n_tests] = cmd;
    t_beats[n_tests] = beats;
    t_seed[n_tests] = data_seed;
    t_last_keep[n_tests] = last_keep;
    t_words[n_tests] = words;
    n_tests++;
  endtask

  // channels alternate so both commands are always pending together
  task automatic fill_table();
    n_tests = 0;
    add_test("tx_full_word", 1'b0, {8'h5a, 32'h0001_0000, 9'h1ff, 23'd64}, 8, 64'h1000, 8'hff, 1);
    add_test("rx_full_word", 1'b1, {8'ha5, 32'h0002_0040, 9'h0aa, 23'd62}, 8, 64'h2000, 8'h3f, 1);
    add_test("tx_two_words", 1'b0, {8'h3c, 32'h0003_0000, 9'h155, 23'd88}, 11, 64'h3000, 8'hff, 2);
    add_test("rx_two_words", 1'b1, {8'hc3, 32'h8004_0100, 9'h1ff, 23'd81}, 11, 64'h4000, 8'h01, 2);
    add_test("tx_short_tail", 1'b0, {8'h0f, 32'hdead_0000, 9'h001, 23'd20}, 3, 64'h5000, 8'h0f, 1);
    add_test("rx_three_words", 1'b1, {8'hf0, 32'h1234_5600, 9'h100, 23'd159}, 20, 64'h6000, 8'h7f, 3);
  endtask

  task automatic set_cmd(input bit ch, input logic valid, input tcp_mem_pkg::mem_cmd_raw_t data);
    if (ch) begin
      rx_cmd_valid = valid;
      rx_cmd_data = data;
    end else begin
      tx_cmd_valid = valid;
      tx_cmd_data = data;
    end
  endtask

  task automatic set_beat(input bit ch, input logic valid, input tcp_mem_pkg::word64_t data,
                          input tcp_mem_pkg::keep8_t keep, input logic last);
    if (ch) begin
      rx_data_valid = valid;
      rx_data_data = data;
      rx_data_keep = keep;
      rx_data_last = last;
    end else begin
      tx_data_valid = valid;
      tx_data_data = data;
      tx_data_keep = keep;
      tx_data_last = last;
    end
  endtask

  // beat k of a word lands in lane k, unfilled lanes stay zero
  task automatic push_expected();
    tcp_mem_pkg::word512_t data;
    tcp_mem_pkg::keep64_t keep;
    int lane;
    bit last;
    for (int t = 0; t < n_tests; t++) begin
      checker_i.expect_cmd(t_name[t], t_chan[t], t_cmd[t][63:32], t_cmd[t][22:0], t_words[t]);
      data = '0;
      keep = '0;
      lane = 0;
      for (int i = 0; i < t_beats[t]; i++) begin
        last = (i == t_beats[t] - 1);
        data[lane*64 +: 64] = t_seed[t] + i;
        keep[lane*8 +: 8] = last ? t_last_keep[t] : 8'hff;
        if (lane == 7 || last) begin
          checker_i.expect_word(t_chan[t], data, keep, last);
          data = '0;
          keep = '0;
          lane = 0;
        end else begin
          lane++;
        end
      end
    end
  endtask

  task automatic drive_channel(input bit ch);
    bit last;
    @(posedge net_clk);
    #1;
    for (int t = 0; t < n_tests; t++) begin
      if (t_chan[t] == ch) begin
        set_cmd(ch, 1'b1, t_cmd[t]);
        do begin
          @(posedge net_clk);
        end while (!(ch ? rx_cmd_ready : tx_cmd_ready));
        #1;
        set_cmd(ch, 1'b0, '0);
        for (int i = 0; i < t_beats[t]; i++) begin
          last = (i == t_beats[t] - 1);
          set_beat(ch, 1'b1, t_seed[t] + i, last ? t_last_keep[t] : 8'hff, last);
          do begin
            @(posedge net_clk);
          end while (!(ch ? rx_data_ready : tx_data_ready));
          #1;
        end
        set_beat(ch, 1'b0, '0, '0, 1'b0);
      end
    end
  endtask

  initial begin
    int total_beats;
    int limit;
    rst = 1'b1;
    set_cmd(1'b0, 1'b0, '0);
    set_cmd(1'b1, 1'b0, '0);
    set_beat(1'b0, 1'b0, '0, '0, 1'b0);
    set_beat(1'b1, 1'b0, '0, '0, 1'b0);
    fill_table();
    total_beats = 0;
    for (int t = 0; t < n_tests; t++) begin
      total_beats += t_beats[t];
    end
    limit = total_beats * 40 + 200; // cycles
    fork
      begin
        repeat (limit) @(posedge net_clk);
        $display("timeout after %0d cycles, %0d of %0d tests finished", limit, tests_done,
                 n_tests);
        $display("Test failed");
        $finish;
      end
    join_none
    push_expected();
    repeat (4) @(posedge net_clk);
    #1;
    rst = 1'b0;
    fork
      drive_channel(1'b0);
      drive_channel(1'b1);
    join
    wait (tests_done == n_tests);
    repeat (4) @(posedge net_clk);
    $display("tests %0d, passed %0d, failed %0d, other errors %0d", tests_done,
             tests_done - tests_failed, tests_failed, other_errors);
    if (tests_failed == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== bench/write_path_checker.sv ====
`timescale 1ns/1ps

module write_path_checker (
  input logic net_clk,
  input logic rst,
  input logic tx_cmd_ready,
  input logic rx_cmd_ready,
  input logic tx_data_ready,
  input logic rx_data_ready,
  input logic mem_cmd_valid,
  input logic mem_cmd_ready,
  input tcp_mem_pkg::mem_addr_t mem_cmd_addr,
  input tcp_mem_pkg::mem_len_t mem_cmd_len,
  input tcp_mem_pkg::chan_t mem_cmd_dest,
  input logic mem_data_valid,
  input logic mem_data_ready,
  input tcp_mem_pkg::word512_t mem_data_data,
  input tcp_mem_pkg::keep64_t mem_data_keep,
  input logic mem_data_last,
  input tcp_mem_pkg::chan_t mem_data_dest,
  output int tests_done,
  output int tests_failed,
  output int other_errors
);

  // expected commands in grant order
  string cmd_name_q[$];
  bit cmd_chan_q[$];
  tcp_mem_pkg::mem_addr_t cmd_addr_q[$];
  tcp_mem_pkg::mem_len_t cmd_len_q[$];
  int cmd_words_q[$];

  // expected words matched per channel
  bit word_chan_q[$];
  tcp_mem_pkg::word512_t word_data_q[$];
  tcp_mem_pkg::keep64_t word_keep_q[$];
  bit word_last_q[$];

  string cur_name [2]; // burst in flight per channel
  bit open [2];
  int cur_errs [2];
  int cur_words [2];
  int exp_words [2];
  bit rst_q;

  task automatic expect_cmd(input string name, input bit chan,
                            input tcp_mem_pkg::mem_addr_t addr,
                            input tcp_mem_pkg::mem_len_t len, input int words);
    cmd_name_q.push_back(name);
    cmd_chan_q.push_back(chan);
    cmd_addr_q.push_back(addr);
    cmd_len_q.push_back(len);
    cmd_words_q.push_back(words);
  endtask

  task automatic expect_word(input bit chan, input tcp_mem_pkg::word512_t data,
                             input tcp_mem_pkg::keep64_t keep, input bit last);
    word_chan_q.push_back(chan);
    word_data_q.push_back(data);
    word_keep_q.push_back(keep);
    word_last_q.push_back(last);
  endtask

  task automatic value_error(input bit ch, input string what,
                             input logic [511:0] exp, input logic [511:0] act);
    $display("mismatch %s %s: expected %0h actual %0h", cur_name[ch], what, exp, act);
    cur_errs[ch]++;
  endtask

  always @(posedge net_clk) begin
    bit ch;
    bit exp_last;
    int idx;
    rst_q <= rst;
    if (rst_q && !rst) begin
      if (mem_cmd_valid || mem_data_valid || tx_cmd_ready || rx_cmd_ready ||
          !tx_data_ready || !rx_data_ready) begin
        $display("outputs were not idle in the first cycle after reset");
        other_errors++;
      end
    end
    if (!rst && mem_cmd_valid && mem_cmd_ready) begin
      if (cmd_name_q.size() == 0) begin
        $display("memory command seen with no test left to match it");
        other_errors++;
      end else begin
        ch = cmd_chan_q.pop_front();
        if (open[ch]) begin
          $display("new command on channel %0d before its previous burst ended", ch);
          other_errors++;
        end
        cur_name[ch] = cmd_name_q.pop_front();
        cur_errs[ch] = 0;
        cur_words[ch] = 0;
        exp_words[ch] = cmd_words_q.pop_front();
        open[ch] = 1'b1;
        if (mem_cmd_dest !== ch)
          value_error(ch, "cmd dest (burst order)", ch, mem_cmd_dest);
        if (mem_cmd_addr !== cmd_addr_q[0])
          value_error(ch, "cmd addr", cmd_addr_q[0], mem_cmd_addr);
        if (mem_cmd_len !== cmd_len_q[0])
          value_error(ch, "cmd len", cmd_len_q[0], mem_cmd_len);
        void'(cmd_addr_q.pop_front());
        void'(cmd_len_q.pop_front());
      end
    end
    if (!rst && mem_data_valid && mem_data_ready) begin
      ch = mem_data_dest;
      idx = -1;
      for (int i = word_chan_q.size() - 1; i >= 0; i--) begin
        if (word_chan_q[i] == ch)
          idx = i; // oldest entry of this channel
      end
      if (!open[ch]) begin
        $display("memory word on channel %0d arrived before its command", ch);
        other_errors++;
      end else if (idx < 0) begin
        $display("extra memory word on channel %0d", ch);
        other_errors++;
      end else begin
        exp_last = word_last_q[idx];
        if (mem_data_data !== word_data_q[idx])
          value_error(ch, "data", word_data_q[idx], mem_data_data);
        if (mem_data_keep !== word_keep_q[idx])
          value_error(ch, "keep", word_keep_q[idx], mem_data_keep);
        if (mem_data_last !== exp_last)
          value_error(ch, "last", exp_last, mem_data_last);
        word_chan_q.delete(idx);
        word_data_q.delete(idx);
        word_keep_q.delete(idx);
        word_last_q.delete(idx);
        cur_words[ch]++;
        if (mem_data_last === 1'b1) begin
          if (cur_words[ch] != exp_words[ch])
            value_error(ch, "word count", exp_words[ch], cur_words[ch]);
          if (cur_errs[ch] == 0) begin
            $display("pass %s", cur_name[ch]);
          end else begin
            $display("fail %s with %0d errors", cur_name[ch], cur_errs[ch]);
            tests_failed++;
          end
          tests_done++;
          open[ch] = 1'b0;
        end
      end
    end
  end

endmodule

// ==== src/tcp_mem_write_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_mem_consts.svh"

module tcp_mem_write_path (
  input logic net_clk,
  input logic rst,

  // write commands
  input logic tx_cmd_valid,
  output logic tx_cmd_ready,
  input tcp_mem_pkg::mem_cmd_raw_t tx_cmd_data,
  input logic rx_cmd_valid,
  output logic rx_cmd_ready,
  input tcp_mem_pkg::mem_cmd_raw_t rx_cmd_data,

  // tx buffer write data
  input logic tx_data_valid,
  output logic tx_data_ready,
  input tcp_mem_pkg::word64_t tx_data_data,
  input tcp_mem_pkg::keep8_t tx_data_keep,
  input logic tx_data_last,

  // rx buffer write data
  input logic rx_data_valid,
  output logic rx_data_ready,
  input tcp_mem_pkg::word64_t rx_data_data,
  input tcp_mem_pkg::keep8_t rx_data_keep,
  input logic rx_data_last,

  // memory side
  output logic mem_cmd_valid,
  input logic mem_cmd_ready,
  output tcp_mem_pkg::mem_addr_t mem_cmd_addr,
  output tcp_mem_pkg::mem_len_t mem_cmd_len,
  output tcp_mem_pkg::chan_t mem_cmd_dest,

  output logic mem_data_valid,
  input logic mem_data_ready,
  output tcp_mem_pkg::word512_t mem_data_data,
  output tcp_mem_pkg::keep64_t mem_data_keep,
  output logic mem_data_last,
  output tcp_mem_pkg::chan_t mem_data_dest
);

  axis_word_if #(.DATA_W(`TCP_NARROW_W)) tx_beat_if ();
  axis_word_if #(.DATA_W(`TCP_NARROW_W)) rx_beat_if ();
  axis_word_if #(.DATA_W(`TCP_WIDE_W)) tx_word_if ();
  axis_word_if #(.DATA_W(`TCP_WIDE_W)) rx_word_if ();
  axis_word_if #(.DATA_W(`TCP_WIDE_W)) mem_data_if ();

  // narrow streams in
  assign tx_beat_if.valid = tx_data_valid;
  assign tx_beat_if.data = tx_data_data;
  assign tx_beat_if.keep = tx_data_keep;
  assign tx_beat_if.last = tx_data_last;
  assign tx_data_ready = tx_beat_if.ready;

  assign rx_beat_if.valid = rx_data_valid;
  assign rx_beat_if.data = rx_data_data;
  assign rx_beat_if.keep = rx_data_keep;
  assign rx_beat_if.last = rx_data_last;
  assign rx_data_ready = rx_beat_if.ready;

  // merged memory data out
  assign mem_data_valid = mem_data_if.valid;
  assign mem_data_data = mem_data_if.data;
  assign mem_data_keep = mem_data_if.keep;
  assign mem_data_last = mem_data_if.last;
  assign mem_data_if.ready = mem_data_ready;

  axis_64_to_512_upsizer tx_upsizer_i (
    .net_clk (net_clk),
    .rst     (rst),
    .s       (tx_beat_if.sink),
    .m       (tx_word_if.source)
  );

  axis_64_to_512_upsizer rx_upsizer_i (
    .net_clk (net_clk),
    .rst     (rst),
    .s       (rx_beat_if.sink),
    .m       (rx_word_if.source)
  );

  mem_write_arbiter arbiter_i (
    .net_clk       (net_clk),
    .rst           (rst),
    .tx_cmd_valid  (tx_cmd_valid),
    .tx_cmd_ready  (tx_cmd_ready),
    .tx_cmd_data   (tx_cmd_data),
    .rx_cmd_valid  (rx_cmd_valid),
    .rx_cmd_ready  (rx_cmd_ready),
    .rx_cmd_data   (rx_cmd_data),
    .tx_word       (tx_word_if.sink),
    .rx_word       (rx_word_if.sink),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_addr  (mem_cmd_addr),
    .mem_cmd_len   (mem_cmd_len),
    .mem_cmd_dest  (mem_cmd_dest),
    .mem_data      (mem_data_if.source),
    .mem_data_dest (mem_data_dest)
  );

endmodule

`default_nettype wire

// ==== src/mem_write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_mem_consts.svh"

module mem_write_arbiter (
  input logic net_clk,
  input logic rst,

  // per-channel write commands
  input logic tx_cmd_valid,
  output logic tx_cmd_ready,
  input tcp_mem_pkg::mem_cmd_raw_t tx_cmd_data,
  input logic rx_cmd_valid,
  output logic rx_cmd_ready,
  input tcp_mem_pkg::mem_cmd_raw_t rx_cmd_data,

  // per-channel packed words
  axis_word_if.sink tx_word,
  axis_word_if.sink rx_word,

  // memory write command port
  output logic mem_cmd_valid,
  input logic mem_cmd_ready,
  output tcp_mem_pkg::mem_addr_t mem_cmd_addr,
  output tcp_mem_pkg::mem_len_t mem_cmd_len,
  output tcp_mem_pkg::chan_t mem_cmd_dest,

  // memory write data port
  axis_word_if.source mem_data,
  output tcp_mem_pkg::chan_t mem_data_dest
);

  tcp_mem_pkg::arb_state_e state;
  tcp_mem_pkg::chan_t last_win; // winner of the previous grant
  tcp_mem_pkg::chan_t pick;
  tcp_mem_pkg::chan_t cur_chan; // channel owning the burst
  tcp_mem_pkg::mem_cmd_raw_t cmd_word;
  tcp_mem_pkg::mem_addr_t cmd_addr;
  tcp_mem_pkg::mem_len_t cmd_len;

  logic in_idle;
  logic cmd_take;
  logic passing;
  logic sel_rx;
  logic burst_done;

  // round robin, only matters when both are pending
  always_comb begin
    if (tx_cmd_valid && rx_cmd_valid) begin
      pick = ~last_win;
    end else if (rx_cmd_valid) begin
      pick = `TCP_CHAN_RX;
    end else begin
      pick = `TCP_CHAN_TX;
    end
  end

  assign in_idle = (state == tcp_mem_pkg::idle);
  assign tx_cmd_ready = in_idle & tx_cmd_valid & (pick == `TCP_CHAN_TX);
  assign rx_cmd_ready = in_idle & rx_cmd_valid & (pick == `TCP_CHAN_RX);
  assign cmd_take = tx_cmd_ready | rx_cmd_ready;
  assign cmd_word = (pick == `TCP_CHAN_RX) ? rx_cmd_data : tx_cmd_data;

  // data is steered straight through, no extra register stage
  assign passing = (state == tcp_mem_pkg::pass_data);
  assign sel_rx = (cur_chan == `TCP_CHAN_RX);

  assign mem_data.valid = passing & (sel_rx ? rx_word.valid : tx_word.valid);
  assign mem_data.data = sel_rx ? rx_word.data : tx_word.data;
  assign mem_data.keep = sel_rx ? rx_word.keep : tx_word.keep;
  assign mem_data.last = sel_rx ? rx_word.last : tx_word.last;

  assign tx_word.ready = passing & ~sel_rx & mem_data.ready; // other side just holds
  assign rx_word.ready = passing & sel_rx & mem_data.ready;

  assign burst_done = mem_data.valid & mem_data.ready & mem_data.last;

  always_ff @(posedge net_clk) begin
    if (rst) begin
      state <= tcp_mem_pkg::idle;
      last_win <= `TCP_CHAN_RX; // so tx wins the first tie
    end else begin
      case (state)
        tcp_mem_pkg::idle: begin
          if (cmd_take) begin
            state <= tcp_mem_pkg::issue_cmd;
            last_win <= pick;
          end
        end
        tcp_mem_pkg::issue_cmd: begin
          if (mem_cmd_ready) begin
            state <= tcp_mem_pkg::pass_data;
          end
        end
        tcp_mem_pkg::pass_data: begin
          if (burst_done) begin
            state <= tcp_mem_pkg::idle;
          end
        end
        default: state <= tcp_mem_pkg::idle;
      endcase
    end
  end

  // command fields, fixed positions in the raw word
  always_ff @(posedge net_clk) begin
    if (cmd_take) begin
      cmd_addr <= cmd_word[`TCP_CMD_ADDR_MSB:`TCP_CMD_ADDR_LSB];
      cmd_len <= cmd_word[`TCP_CMD_LEN_MSB:0];
      cur_chan <= pick;
    end
  end

  assign mem_cmd_valid = (state == tcp_mem_pkg::issue_cmd);
  assign mem_cmd_addr = cmd_addr;
  assign mem_cmd_len = cmd_len;
  assign mem_cmd_dest = cur_chan;
  assign mem_data_dest = cur_chan;

endmodule

`default_nettype wire

// ==== src/axis_64_to_512_upsizer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_mem_consts.svh"

module axis_64_to_512_upsizer (
  input logic net_clk,
  input logic rst,
  axis_word_if.sink s,   // 64-bit beats
  axis_word_if.source m  // 512-bit words
);

  localparam int BEATS = `TCP_BEATS_PER_WORD;
  localparam int NARROW_W = `TCP_NARROW_W;
  localparam int LANE_KEEP_W = NARROW_W / 8;
  localparam int LANE_W = $clog2(BEATS);

  logic [LANE_W-1:0] lane_cnt; // lane the next beat lands in

  tcp_mem_pkg::word512_t acc_data;
  tcp_mem_pkg::keep64_t acc_keep;
  tcp_mem_pkg::word512_t merged_data;
  tcp_mem_pkg::keep64_t merged_keep;

  // held output word
  logic out_valid;
  tcp_mem_pkg::word512_t out_data;
  tcp_mem_pkg::keep64_t out_keep;
  logic out_last;

  logic beat_take;
  logic flush;

  // stall the input only while a finished word waits
  assign s.ready = ~out_valid | m.ready;
  assign beat_take = s.valid & s.ready;
  assign flush = s.last | (lane_cnt == LANE_W'(BEATS - 1));

  // lanes below the counter come from the accumulator, the current lane
  // from the incoming beat, the rest stay zero
  always_comb begin
    merged_data = '0;
    merged_keep = '0;
    for (int i = 0; i < BEATS; i++) begin
      if (i < lane_cnt) begin
        merged_data[i*NARROW_W +: NARROW_W] = acc_data[i*NARROW_W +: NARROW_W];
        merged_keep[i*LANE_KEEP_W +: LANE_KEEP_W] = acc_keep[i*LANE_KEEP_W +: LANE_KEEP_W];
      end else if (i == lane_cnt) begin
        merged_data[i*NARROW_W +: NARROW_W] = s.data;
        merged_keep[i*LANE_KEEP_W +: LANE_KEEP_W] = s.keep;
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (rst) begin
      lane_cnt <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && m.ready) begin
        out_valid <= 1'b0; // word taken
      end
      if (beat_take) begin
        if (flush) begin
          lane_cnt <= '0; // next word restarts at lane 0
          out_valid <= 1'b1;
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (beat_take) begin
      acc_data <= merged_data;
      acc_keep <= merged_keep;
      if (flush) begin
        out_data <= merged_data;
        out_keep <= merged_keep;
        out_last <= s.last; // short word only when the burst ends
      end
    end
  end

  assign m.valid = out_valid;
  assign m.data = out_data;
  assign m.keep = out_keep;
  assign m.last = out_last;

endmodule

`default_nettype wire

// ==== src/axis_word_if.sv ====
`timescale 1ns/1ps

`include "tcp_mem_consts.svh"

interface axis_word_if #(
  parameter int DATA_W = `TCP_NARROW_W
);

  localparam int KEEP_W = DATA_W / 8; // one enable per byte

  logic              valid;
  logic              ready;
  logic [DATA_W-1:0] data;
  logic [KEEP_W-1:0] keep;
  logic              last;

  modport source (
    output valid, data, keep, last,
    input  ready
  );

  modport sink (
    input  valid, data, keep, last,
    output ready
  );

endinterface

// ==== src/tcp_mem_pkg.sv ====
`include "tcp_mem_consts.svh"

package tcp_mem_pkg;

  // narrow engine-side beat
  typedef logic [`TCP_NARROW_W-1:0] word64_t;
  typedef logic [`TCP_NARROW_W/8-1:0] keep8_t;

  // memory word
  typedef logic [`TCP_WIDE_W-1:0] word512_t;
  typedef logic [`TCP_WIDE_W/8-1:0] keep64_t;

  typedef logic [`TCP_CMD_W-1:0] mem_cmd_raw_t; // as issued by the engine

  // fields pulled out of the raw command
  typedef logic [`TCP_CMD_ADDR_MSB-`TCP_CMD_ADDR_LSB:0] mem_addr_t;
  typedef logic [`TCP_CMD_LEN_MSB:0] mem_len_t;

  typedef logic [0:0] chan_t; // tx or rx buffer

  typedef enum logic [1:0] {
    idle,
    issue_cmd,
    pass_data
  } arb_state_e;

endpackage

// ==== src/tcp_mem_consts.svh ====
`ifndef TCP_MEM_CONSTS_SVH
`define TCP_MEM_CONSTS_SVH

// beat and word widths
`define TCP_NARROW_W 64
`define TCP_WIDE_W 512
`define TCP_BEATS_PER_WORD 8

// packed write command from the engine
`define TCP_CMD_W 72
`define TCP_CMD_ADDR_MSB 63
`define TCP_CMD_ADDR_LSB 32
`define TCP_CMD_LEN_MSB 22 // length starts at bit 0

// buffer channels, also used as memory dest
`define TCP_CHAN_TX 1'b0
`define TCP_CHAN_RX 1'b1

`endif
